// File: common/rvvi_trace_pkg.sv
// Trace widths, traced CSR table and change-record FIFO sizing
package rvvi_trace_pkg;

    ////////////////////
    // Datapath widths
    ////////////////////

    // Data, PC and CSR value width
    localparam int XLEN = 32;

    // Retirement order counter
    localparam int ORDER_W = 64;

    // GPR file
    localparam int REG_ADDR_W = 5;
    localparam int NUM_GPR    = 32;

    ////////////////////
    // Traced CSRs
    ////////////////////

    // Lane order is mstatus, mie, mtvec, mepc
    localparam int NUM_CSR    = 4;
    localparam int CSR_ADDR_W = 12;

    // Lane 0 sits in the low bits
    localparam logic [NUM_CSR-1:0][CSR_ADDR_W-1:0] CSR_ADDR_TABLE = {
        12'h341,
        12'h305,
        12'h304,
        12'h300
    };

    ////////////////////
    // Interrupt events
    ////////////////////

    // One bit per interrupt line
    localparam int NUM_IRQ   = 32;
    localparam int IRQ_IDX_W = 5;

    // Change records waiting for serialization
    localparam int NET_FIFO_DEPTH = 4;

    // Change mask in the upper half, sampled levels in the lower half
    localparam int NET_REC_W = 2 * NUM_IRQ;

endpackage

// File: verilog/retire_stage.sv
// Retirement record register stage with order continuity check
`timescale 1ns/1ps

module retire_stage
    import rvvi_trace_pkg::*;
(
    input  logic               rvvi,
    input  logic               rst,
    input  logic               rvfi_valid,
    input  logic [ORDER_W-1:0] rvfi_order,
    input  logic [XLEN-1:0]    rvfi_insn,
    input  logic               rvfi_trap,
    input  logic               rvfi_intr,
    input  logic [XLEN-1:0]    rvfi_pc_rdata,
    input  logic [XLEN-1:0]    rvfi_pc_wdata,
    output logic               trace_valid,
    output logic [ORDER_W-1:0] trace_order,
    output logic [XLEN-1:0]    trace_insn,
    output logic               trace_trap,
    output logic               trace_intr,
    output logic [XLEN-1:0]    trace_pc_rdata,
    output logic [XLEN-1:0]    trace_pc_wdata
);

    // Order number of the most recent retirement
    logic [ORDER_W-1:0] last_order;
    // Set once anything has retired since reset
    logic               have_prev;

    // Valid strobe, one new retirement per cycle
    always_ff @(posedge rvvi) begin
        if (rst) begin
            trace_valid <= 1'b0;
            have_prev   <= 1'b0;
        end else begin
            trace_valid <= rvfi_valid;
            if (rvfi_valid) begin
                have_prev <= 1'b1;
            end
        end
    end

    // Record payload follows the port every edge
    always_ff @(posedge rvvi) begin
        trace_order    <= rvfi_order;
        trace_insn     <= rvfi_insn;
        trace_trap     <= rvfi_trap;
        trace_intr     <= rvfi_intr;
        trace_pc_rdata <= rvfi_pc_rdata;
        trace_pc_wdata <= rvfi_pc_wdata;
    end

    // Idle cycles in between leave it untouched
    always_ff @(posedge rvvi) begin
        if (rvfi_valid) begin
            last_order <= rvfi_order;
        end
    end

    // Retirements may be spread out, but their order numbers never skip
    a_order_step : assert property (@(posedge rvvi) disable iff (rst)
        (rvfi_valid && have_prev) |-> (rvfi_order == last_order + ORDER_W'(1)));

endmodule

// File: verilog/gpr_writeback.sv
// GPR writeback one-hot mask and data register
`timescale 1ns/1ps

module gpr_writeback
    import rvvi_trace_pkg::*;
(
    input  logic                  rvvi,
    input  logic                  rst,
    input  logic                  rvfi_valid,
    input  logic [REG_ADDR_W-1:0] rvfi_rd_addr,
    input  logic [XLEN-1:0]       rvfi_rd_wdata,
    output logic [NUM_GPR-1:0]    x_wb,
    output logic [XLEN-1:0]       x_wdata
);

    logic [NUM_GPR-1:0] wb_dec;

    ////////////////////
    // Address decode
    ////////////////////

    // x0 is hardwired, so writes to it are never reported
    always_comb begin
        wb_dec = '0;
        if (rvfi_valid && (rvfi_rd_addr != '0)) begin
            wb_dec = NUM_GPR'(1) << rvfi_rd_addr;
        end
    end

    // Mask register
    always_ff @(posedge rvvi) begin
        if (rst) begin
            x_wb <= '0;
        end else begin
            x_wb <= wb_dec;
        end
    end

    // Write data goes out whether or not a bit is set
    always_ff @(posedge rvvi) begin
        x_wdata <= rvfi_rd_wdata;
    end

    // Single destination per retirement, never x0
    a_wb_onehot : assert property (@(posedge rvvi) disable iff (rst)
        $onehot0(x_wb) && !x_wb[0]);

endmodule

// File: verilog/csr_merge.sv
// Single CSR lane merge with written-since-retirement flag
`timescale 1ns/1ps

module csr_merge
    import rvvi_trace_pkg::*;
(
    input  logic            rvvi,
    input  logic            rst,
    input  logic            rvfi_valid,
    input  logic [XLEN-1:0] csr_wdata,
    input  logic [XLEN-1:0] csr_rdata,
    input  logic [XLEN-1:0] csr_wmask,
    output logic [XLEN-1:0] csr_value,
    output logic            csr_wb
);

    // Bitwise pick between write and read data
    logic [XLEN-1:0] merged;
    logic            changed;

    ////////////////////
    // Masked merge
    ////////////////////

    // Masked bits take the write data, the rest keep the read data
    assign merged = (csr_wdata & csr_wmask) | (csr_rdata & ~csr_wmask);

    // Compared against what went out at the last edge
    assign changed = (merged != csr_value);

    // Starts from zero so a nonzero first value counts as a write
    always_ff @(posedge rvvi) begin
        if (rst) begin
            csr_value <= '0;
        end else begin
            csr_value <= merged;
        end
    end

    ////////////////////
    // Written flag
    ////////////////////

    // A change wins over the retirement clear
    always_ff @(posedge rvvi) begin
        if (rst) begin
            csr_wb <= 1'b0;
        end else if (changed) begin
            csr_wb <= 1'b1;
        end else if (rvfi_valid) begin
            csr_wb <= 1'b0;
        end
    end

endmodule

// File: irq_event/net_event_fifo.sv
// Circular FIFO for interrupt change records
`timescale 1ns/1ps

module net_event_fifo
    import rvvi_trace_pkg::*;
#(
    parameter int DEPTH = NET_FIFO_DEPTH
) (
    input  logic                 rvvi,
    input  logic                 rst,
    input  logic                 push,
    input  logic [NET_REC_W-1:0] push_rec,
    input  logic                 pop,
    output logic [NET_REC_W-1:0] head_rec,
    output logic                 empty,
    output logic                 full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage
    logic [NET_REC_W-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign wr_en    = push && !full;
    assign rd_en    = pop && !empty;
    assign head_rec = mem[rd_ptr];

    // Write side
    always_ff @(posedge rvvi) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    ////////////////////
    // Pointers and fill
    ////////////////////

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge rvvi) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the fill alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Producer must drop records itself when there is no room
    a_no_push_full : assert property (@(posedge rvvi) disable iff (rst)
        push |-> !full);

endmodule

// File: irq_event/irq_event_monitor.sv
// Interrupt line change detector and single-line event serializer
`timescale 1ns/1ps

module irq_event_monitor
    import rvvi_trace_pkg::*;
(
    input  logic                 rvvi,
    input  logic                 rst,
    input  logic [NUM_IRQ-1:0]   irq,
    output logic                 net_valid,
    output logic [IRQ_IDX_W-1:0] net_index,
    output logic                 net_level,
    output logic                 net_overflow
);

    logic [NUM_IRQ-1:0]   irq_prev;
    logic [NUM_IRQ-1:0]   change;
    logic                 fifo_push;
    logic                 fifo_pop;
    logic [NET_REC_W-1:0] head_rec;
    logic                 fifo_empty;
    logic                 fifo_full;

    // Bits of the head record not yet emitted
    logic [NUM_IRQ-1:0]   rem_mask;
    logic                 rem_valid;
    logic [NUM_IRQ-1:0]   cur_mask;
    logic [NUM_IRQ-1:0]   next_mask;
    logic [NUM_IRQ-1:0]   head_level;
    logic [IRQ_IDX_W-1:0] low_idx;

    ////////////////////
    // Change detection
    ////////////////////

    assign change    = irq ^ irq_prev;
    assign fifo_push = (|change) && !fifo_full;

    always_ff @(posedge rvvi) begin
        if (rst) begin
            irq_prev     <= '0;
            net_overflow <= 1'b0;
        end else begin
            irq_prev <= irq;
            // Sticky once a record is lost
            if ((|change) && fifo_full) begin
                net_overflow <= 1'b1;
            end
        end
    end

    net_event_fifo u_fifo (
        .rvvi     (rvvi),
        .rst      (rst),
        .push     (fifo_push),
        .push_rec ({change, irq}),
        .pop      (fifo_pop),
        .head_rec (head_rec),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    ////////////////////
    // Serializer
    ////////////////////

    // Fresh head starts from its full mask
    assign cur_mask   = rem_valid ? rem_mask : head_rec[NET_REC_W-1 -: NUM_IRQ];
    assign head_level = head_rec[NUM_IRQ-1:0];
    // Clear lowest set bit
    assign next_mask  = cur_mask & (cur_mask - 1'b1);
    assign fifo_pop   = !fifo_empty && (next_mask == '0);

    // Lowest set bit wins, hence the downward scan
    always_comb begin
        low_idx = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (cur_mask[i]) begin
                low_idx = IRQ_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge rvvi) begin
        if (rst) begin
            net_valid <= 1'b0;
            rem_valid <= 1'b0;
        end else begin
            net_valid <= !fifo_empty;
            rem_valid <= !fifo_empty && (next_mask != '0);
        end
    end

    // One event per cycle while the FIFO holds a record
    always_ff @(posedge rvvi) begin
        rem_mask  <= next_mask;
        net_index <= low_idx;
        net_level <= head_level[low_idx];
    end

    // A partly emitted record stays at the head until its last bit
    a_no_pop_empty : assert property (@(posedge rvvi) disable iff (rst)
        rem_valid |-> !fifo_empty);

endmodule

// File: verilog/rvvi_trace_bridge.sv
// Formal-interface to verification-interface trace bridge top level
`timescale 1ns/1ps

module rvvi_trace_bridge
    import rvvi_trace_pkg::*;
(
    input  logic                                   rvvi,
    input  logic                                   rst,
    // Retirement
    input  logic                                   rvfi_valid,
    input  logic [ORDER_W-1:0]                     rvfi_order,
    input  logic [XLEN-1:0]                        rvfi_insn,
    input  logic                                   rvfi_trap,
    input  logic                                   rvfi_intr,
    input  logic [XLEN-1:0]                        rvfi_pc_rdata,
    input  logic [XLEN-1:0]                        rvfi_pc_wdata,
    // GPR write
    input  logic [REG_ADDR_W-1:0]                  rvfi_rd_addr,
    input  logic [XLEN-1:0]                        rvfi_rd_wdata,
    // CSR lanes
    input  logic [NUM_CSR-1:0][XLEN-1:0]           rvfi_csr_wdata,
    input  logic [NUM_CSR-1:0][XLEN-1:0]           rvfi_csr_rdata,
    input  logic [NUM_CSR-1:0][XLEN-1:0]           rvfi_csr_wmask,
    // Interrupt lines
    input  logic [NUM_IRQ-1:0]                     irq,
    // Retirement trace
    output logic                                   trace_valid,
    output logic [ORDER_W-1:0]                     trace_order,
    output logic [XLEN-1:0]                        trace_insn,
    output logic                                   trace_trap,
    output logic                                   trace_intr,
    output logic [XLEN-1:0]                        trace_pc_rdata,
    output logic [XLEN-1:0]                        trace_pc_wdata,
    // GPR trace
    output logic [NUM_GPR-1:0]                     x_wb,
    output logic [XLEN-1:0]                        x_wdata,
    // CSR trace
    output logic [NUM_CSR-1:0][XLEN-1:0]           csr_value,
    output logic [NUM_CSR-1:0]                     csr_wb,
    output logic [NUM_CSR-1:0][CSR_ADDR_W-1:0]     csr_addr,
    // Interrupt events
    output logic                                   net_valid,
    output logic [IRQ_IDX_W-1:0]                   net_index,
    output logic                                   net_level,
    output logic                                   net_overflow
);

    ////////////////////
    // Retirement record
    ////////////////////

    retire_stage u_retire (
        .rvvi           (rvvi),
        .rst            (rst),
        .rvfi_valid     (rvfi_valid),
        .rvfi_order     (rvfi_order),
        .rvfi_insn      (rvfi_insn),
        .rvfi_trap      (rvfi_trap),
        .rvfi_intr      (rvfi_intr),
        .rvfi_pc_rdata  (rvfi_pc_rdata),
        .rvfi_pc_wdata  (rvfi_pc_wdata),
        .trace_valid    (trace_valid),
        .trace_order    (trace_order),
        .trace_insn     (trace_insn),
        .trace_trap     (trace_trap),
        .trace_intr     (trace_intr),
        .trace_pc_rdata (trace_pc_rdata),
        .trace_pc_wdata (trace_pc_wdata)
    );

    gpr_writeback u_gpr (
        .rvvi          (rvvi),
        .rst           (rst),
        .rvfi_valid    (rvfi_valid),
        .rvfi_rd_addr  (rvfi_rd_addr),
        .rvfi_rd_wdata (rvfi_rd_wdata),
        .x_wb          (x_wb),
        .x_wdata       (x_wdata)
    );

    ////////////////////
    // CSR lanes
    ////////////////////

    // Fixed addresses, lane by lane
    assign csr_addr = CSR_ADDR_TABLE;

    for (genvar i = 0; i < NUM_CSR; i++) begin : g_csr
        csr_merge u_csr (
            .rvvi       (rvvi),
            .rst        (rst),
            .rvfi_valid (rvfi_valid),
            .csr_wdata  (rvfi_csr_wdata[i]),
            .csr_rdata  (rvfi_csr_rdata[i]),
            .csr_wmask  (rvfi_csr_wmask[i]),
            .csr_value  (csr_value[i]),
            .csr_wb     (csr_wb[i])
        );
    end

    // Interrupt change events
    irq_event_monitor u_irq (
        .rvvi         (rvvi),
        .rst          (rst),
        .irq          (irq),
        .net_valid    (net_valid),
        .net_index    (net_index),
        .net_level    (net_level),
        .net_overflow (net_overflow)
    );

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps

module tb_clock_gen (
    output logic rvvi,
    output logic rst
);

    // 100 ns period
    initial begin
        rvvi = 1'b0;
        forever #50 rvvi = ~rvvi;
    end

    // Held over eight rising edges, released right after the eighth
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge rvvi);
        rst <= 1'b0;
    end

endmodule

// File: tb/rvvi_trace_bridge_tb.sv
// Random-stimulus testbench with a cycle model of the trace bridge
`timescale 1ns/1ps

module rvvi_trace_bridge_tb
    import rvvi_trace_pkg::*;
();

    localparam int NUM_CYCLES    = 2000;
    localparam int RESET_TIMEOUT = 40;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int QUIET_CYCLES  = 40;

    // Standard machine-mode addresses, lane order mstatus, mie, mtvec, mepc
    localparam logic [11:0] CSR_STD_ADDR [NUM_CSR] = '{12'h300, 12'h304, 12'h305, 12'h341};

    logic                                   rvvi;
    logic                                   rst;
    logic                                   rvfi_valid;
    logic [ORDER_W-1:0]                     rvfi_order;
    logic [XLEN-1:0]                        rvfi_insn;
    logic                                   rvfi_trap;
    logic                                   rvfi_intr;
    logic [XLEN-1:0]                        rvfi_pc_rdata;
    logic [XLEN-1:0]                        rvfi_pc_wdata;
    logic [REG_ADDR_W-1:0]                  rvfi_rd_addr;
    logic [XLEN-1:0]                        rvfi_rd_wdata;
    logic [NUM_CSR-1:0][XLEN-1:0]           rvfi_csr_wdata;
    logic [NUM_CSR-1:0][XLEN-1:0]           rvfi_csr_rdata;
    logic [NUM_CSR-1:0][XLEN-1:0]           rvfi_csr_wmask;
    logic [NUM_IRQ-1:0]                     irq;
    logic                                   trace_valid;
    logic [ORDER_W-1:0]                     trace_order;
    logic [XLEN-1:0]                        trace_insn;
    logic                                   trace_trap;
    logic                                   trace_intr;
    logic [XLEN-1:0]                        trace_pc_rdata;
    logic [XLEN-1:0]                        trace_pc_wdata;
    logic [NUM_GPR-1:0]                     x_wb;
    logic [XLEN-1:0]                        x_wdata;
    logic [NUM_CSR-1:0][XLEN-1:0]           csr_value;
    logic [NUM_CSR-1:0]                     csr_wb;
    logic [NUM_CSR-1:0][CSR_ADDR_W-1:0]     csr_addr;
    logic                                   net_valid;
    logic [IRQ_IDX_W-1:0]                   net_index;
    logic                                   net_level;
    logic                                   net_overflow;

    // Model state
    logic [XLEN-1:0]      model_csr_value [NUM_CSR];
    logic [NUM_CSR-1:0]   model_csr_wb;
    logic [NUM_IRQ-1:0]   model_irq_prev;
    // Change records, mask on top of levels
    logic [NET_REC_W-1:0] rec_q [$];
    // Expected events, index above level
    logic [IRQ_IDX_W:0]   evt_q [$];
    logic [NUM_IRQ-1:0]   rem_mask;
    logic                 have_rem;
    logic                 model_overflow;

    // Stimulus state
    logic [ORDER_W-1:0]   order_cnt;
    int                   burst_left;
    int                   events_seen;
    int                   dropped_recs;

    ////////////////////
    // Clock and DUT
    ////////////////////

    tb_clock_gen u_clk (
        .rvvi (rvvi),
        .rst  (rst)
    );

    // Port names match the testbench signals one for one
    rvvi_trace_bridge DUT (.*);

    ////////////////////
    // Reporting
    ////////////////////

    task automatic fail_stop(input string why);
        $display("%s (time %0t)", why, $time);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Advances the model over the rising edge that just sampled the inputs
    task automatic model_step();
        logic [XLEN-1:0]      merged;
        logic [NUM_IRQ-1:0]   change;
        logic [NUM_IRQ-1:0]   cur;
        logic [NUM_IRQ-1:0]   lvl;
        logic [NET_REC_W-1:0] head;
        logic [IRQ_IDX_W-1:0] idx;
        logic                 found;
        logic                 was_full;

        // Per-bit pick, then change beats retirement clear
        for (int i = 0; i < NUM_CSR; i++) begin
            for (int b = 0; b < XLEN; b++) begin
                merged[b] = rvfi_csr_wmask[i][b] ? rvfi_csr_wdata[i][b] : rvfi_csr_rdata[i][b];
            end
            if (merged != model_csr_value[i]) begin
                model_csr_wb[i] = 1'b1;
            end else if (rvfi_valid) begin
                model_csr_wb[i] = 1'b0;
            end
            model_csr_value[i] = merged;
        end

        // Fill before this edge decides both drop and emission
        was_full = (rec_q.size() == NET_FIFO_DEPTH);
        if (rec_q.size() != 0) begin
            head  = rec_q[0];
            lvl   = head[NUM_IRQ-1:0];
            cur   = have_rem ? rem_mask : head[NET_REC_W-1 -: NUM_IRQ];
            found = 1'b0;
            idx   = '0;
            for (int b = 0; b < NUM_IRQ; b++) begin
                if (cur[b] && !found) begin
                    idx   = IRQ_IDX_W'(b);
                    found = 1'b1;
                end
            end
            evt_q.push_back({idx, lvl[idx]});
            cur[idx] = 1'b0;
            // Last bit of the record retires it
            if (cur == '0) begin
                void'(rec_q.pop_front());
                have_rem = 1'b0;
            end else begin
                rem_mask = cur;
                have_rem = 1'b1;
            end
        end

        change = irq ^ model_irq_prev;
        if (change != '0) begin
            if (was_full) begin
                model_overflow = 1'b1;
                dropped_recs++;
            end else begin
                rec_q.push_back({change, irq});
            end
        end
        model_irq_prev = irq;
    endtask

    ////////////////////
    // Output checks
    ////////////////////

    // Inputs still hold what the last edge sampled
    task automatic check_outputs();
        logic [NUM_GPR-1:0] exp_wb;
        logic [IRQ_IDX_W:0] evt;

        check_value("trace_valid", 64'(trace_valid), 64'(rvfi_valid));
        check_value("trace_order", 64'(trace_order), 64'(rvfi_order));
        check_value("trace_insn", 64'(trace_insn), 64'(rvfi_insn));
        check_value("trace_trap", 64'(trace_trap), 64'(rvfi_trap));
        check_value("trace_intr", 64'(trace_intr), 64'(rvfi_intr));
        check_value("trace_pc_rdata", 64'(trace_pc_rdata), 64'(rvfi_pc_rdata));
        check_value("trace_pc_wdata", 64'(trace_pc_wdata), 64'(rvfi_pc_wdata));

        // x0 and idle cycles leave the mask empty
        exp_wb = '0;
        if (rvfi_valid && (rvfi_rd_addr != '0)) begin
            exp_wb[rvfi_rd_addr] = 1'b1;
        end
        check_value("x_wb", 64'(x_wb), 64'(exp_wb));
        check_value("x_wdata", 64'(x_wdata), 64'(rvfi_rd_wdata));

        for (int i = 0; i < NUM_CSR; i++) begin
            check_value($sformatf("csr_value[%0d] csr 0x%03h", i, CSR_ADDR_TABLE[i]),
                        64'(csr_value[i]), 64'(model_csr_value[i]));
            check_value($sformatf("csr_wb[%0d] csr 0x%03h", i, CSR_ADDR_TABLE[i]),
                        64'(csr_wb[i]), 64'(model_csr_wb[i]));
            check_value($sformatf("csr_addr[%0d]", i), 64'(csr_addr[i]), 64'(CSR_STD_ADDR[i]));
        end

        check_value("net_overflow", 64'(net_overflow), 64'(model_overflow));

        // Events compared in order, whatever cycle they land in
        if (net_valid) begin
            if (evt_q.size() == 0) begin
                fail_stop("Interrupt event emitted with no change pending");
            end else begin
                evt = evt_q.pop_front();
                check_value("net_index", 64'(net_index), 64'(evt[IRQ_IDX_W:1]));
                check_value("net_level", 64'(net_level), 64'(evt[0]));
                events_seen++;
            end
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic drive_random();
        int                   sel;
        int                   nflip;
        logic [IRQ_IDX_W-1:0] flip_idx;

        // Roughly 60% retiring, order runs without gaps
        rvfi_valid = ($urandom_range(99) < 60);
        if (rvfi_valid) begin
            rvfi_order = order_cnt;
            order_cnt  = order_cnt + 64'd1;
        end else begin
            rvfi_order = {$urandom(), $urandom()};
        end
        rvfi_insn     = $urandom();
        rvfi_trap     = ($urandom_range(9) == 0);
        rvfi_intr     = ($urandom_range(9) == 0);
        rvfi_pc_rdata = $urandom();
        rvfi_pc_wdata = $urandom();
        // Extra weight on x0
        if ($urandom_range(9) == 0) begin
            rvfi_rd_addr = '0;
        end else begin
            rvfi_rd_addr = REG_ADDR_W'($urandom_range(31));
        end
        rvfi_rd_wdata = $urandom();

        // Lanes left alone half the time, so the flag can clear and hold
        for (int i = 0; i < NUM_CSR; i++) begin
            if ($urandom_range(1) == 0) begin
                rvfi_csr_wdata[i] = $urandom();
                rvfi_csr_rdata[i] = $urandom();
                sel = $urandom_range(3);
                if (sel == 0) begin
                    rvfi_csr_wmask[i] = '0;
                end else if (sel == 1) begin
                    rvfi_csr_wmask[i] = '1;
                end else begin
                    rvfi_csr_wmask[i] = $urandom();
                end
            end
        end

        // Mostly quiet lines, now and then a burst that overruns the FIFO
        if (burst_left > 0) begin
            nflip = $urandom_range(3, 1);
            burst_left--;
        end else if ($urandom_range(99) < 3) begin
            burst_left = $urandom_range(10, 6);
            nflip      = 2;
        end else begin
            nflip = ($urandom_range(99) < 35) ? 1 : 0;
        end
        for (int k = 0; k < nflip; k++) begin
            flip_idx      = IRQ_IDX_W'($urandom_range(31));
            irq[flip_idx] = ~irq[flip_idx];
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int wait_cnt;

        void'($urandom(32'h49a4_c07e));

        rvfi_valid     = 1'b0;
        rvfi_order     = '0;
        rvfi_insn      = '0;
        rvfi_trap      = 1'b0;
        rvfi_intr      = 1'b0;
        rvfi_pc_rdata  = '0;
        rvfi_pc_wdata  = '0;
        rvfi_rd_addr   = '0;
        rvfi_rd_wdata  = '0;
        rvfi_csr_wdata = '0;
        rvfi_csr_rdata = '0;
        rvfi_csr_wmask = '0;
        irq            = '0;

        // Model starts from the reset state
        for (int i = 0; i < NUM_CSR; i++) begin
            model_csr_value[i] = '0;
        end
        model_csr_wb   = '0;
        model_irq_prev = '0;
        rem_mask       = '0;
        have_rem       = 1'b0;
        model_overflow = 1'b0;
        order_cnt      = '0;
        burst_left     = 0;
        events_seen    = 0;
        dropped_recs   = 0;

        wait_cnt = 0;
        do begin
            @(negedge rvvi);
            wait_cnt++;
            if (wait_cnt > RESET_TIMEOUT) begin
                fail_stop("Reset was never released");
            end
        end while (rst);

        drive_random();
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge rvvi);
            model_step();
            check_outputs();
            drive_random();
        end

        // Drain with retirements stopped and the lines held
        rvfi_valid = 1'b0;
        wait_cnt   = 0;
        do begin
            @(negedge rvvi);
            model_step();
            check_outputs();
            wait_cnt++;
            if (wait_cnt > DRAIN_TIMEOUT) begin
                fail_stop("Pending interrupt events did not arrive in time");
            end
        end while ((rec_q.size() != 0) || (evt_q.size() != 0));

        // Nothing more may show up
        for (int q = 0; q < QUIET_CYCLES; q++) begin
            @(negedge rvvi);
            model_step();
            check_outputs();
        end

        $display("%0d interrupt events checked, %0d change records dropped",
                 events_seen, dropped_recs);
        if ((events_seen == 0) || (dropped_recs == 0)) begin
            fail_stop("Stimulus never produced both interrupt events and an overflow");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: rvvi_trace_bridge.f
common/rvvi_trace_pkg.sv
verilog/retire_stage.sv
verilog/gpr_writeback.sv
verilog/csr_merge.sv
irq_event/net_event_fifo.sv
irq_event/irq_event_monitor.sv
verilog/rvvi_trace_bridge.sv
tb/tb_clock_gen.sv
tb/rvvi_trace_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the trace bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rvvi_trace_bridge.f \
    --top-module rvvi_trace_bridge_tb \
    -o sim_rvvi_trace_bridge

# The log decides the result, so the simulator status is not used here
./obj_dir/sim_rvvi_trace_bridge | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
